// ==== project.f ====
source/jtag_pkg.sv
source/dbg_pkg.sv
source/tap_ctrl_if.sv
source/memi_if.sv
source/tap_controller.sv
source/core_dbg_port.sv
source/dbg_reg_bank.sv
source/jtag_dbg_top.sv
tests/tb_clock.sv
tests/jtag_dbg_chk.sv
tests/jtag_dbg_tb.sv

// ==== Makefile ====
# Verilator build and run for the JTAG debug access testbench
# Override any variable on the command line, e.g. make run BUILD_DIR=build

VERILATOR ?= verilator
TOP       ?= jtag_dbg_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
RUN_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= Test completed successfully

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: compile
	out="$$(./$(SIM_BIN) $(RUN_ARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== tests/jtag_dbg_tb.sv ====
// Directed testbench for the JTAG debug access subsystem
// Drives tms and tdi through IR and DR scans and checks the scanned-out words
`timescale 1ns/1ps
`default_nettype none

module jtag_dbg_tb;

    import jtag_pkg::*;
    import dbg_pkg::*;

    localparam int RESET_CYCLES  = 16;
    localparam int STATE_TIMEOUT = 8; // TLR is at most 5 tms-high edges away

    logic        tck;
    logic        state_test_logic_reset;
    logic        tms;
    logic        tdi;
    logic        tdo;
    logic [4:0]  bank_addr; // Shared by the bus tests
    logic [31:0] data_0;    // Last value written to bank 0

    tb_clock tb_clock_i (.tck(tck));

    jtag_dbg_top jtag_dbg_top_i (
        .tck                    (tck),
        .state_test_logic_reset (state_test_logic_reset),
        .tms                    (tms),
        .tdi                    (tdi),
        .tdo                    (tdo)
    );

    task automatic check_value(input string test_name, input logic [35:0] expected,
                               input logic [35:0] actual);
        if (expected !== actual) begin
            $display("error %s expected %h actual %h", test_name, expected, actual);
            $display("Test failed");
            $fatal(1, "Mismatch in %s", test_name);
        end
    endtask

    // One TAP edge, tdo sampled mid-cycle before the edge shifts it out
    task automatic tck_cycle(input logic tms_v, input logic tdi_v, output logic tdo_v);
        tms <= tms_v;
        tdi <= tdi_v;
        @(negedge tck);
        tdo_v = tdo;
        @(posedge tck);
    endtask

    // Target must be a self-loop for tms_v
    task automatic wait_for_state(input tap_state_t target, input logic tms_v,
                                  input string state_name);
        int   cycles;
        logic found;
        cycles = 0;
        found  = 1'b0;
        while (!found && cycles < STATE_TIMEOUT) begin
            tms <= tms_v;
            tdi <= 1'b0;
            @(negedge tck);
            found = (jtag_dbg_top_i.tap_controller_i.tap_state == target);
            @(posedge tck);
            cycles++;
        end
        if (!found) begin
            $display("TAP did not reach %s within %0d cycles", state_name, STATE_TIMEOUT);
            $display("Test failed");
            $fatal(1, "TAP state timeout");
        end
    endtask

    task automatic tap_reset();
        wait_for_state(TEST_LOGIC_RESET, 1'b1, "Test-Logic-Reset");
    endtask

    task automatic goto_idle();
        wait_for_state(RUN_TEST_IDLE, 1'b0, "Run-Test-Idle");
    endtask

    // Starts in Run-Test-Idle or Update-*, ends in Run-Test-Idle
    task automatic scan_ir(input logic [IR_WIDTH-1:0] code, output logic [IR_WIDTH-1:0] captured);
        logic bit_out;
        tck_cycle(1'b1, 1'b0, bit_out); // Select-DR-Scan
        tck_cycle(1'b1, 1'b0, bit_out); // Select-IR-Scan
        tck_cycle(1'b0, 1'b0, bit_out); // Capture-IR
        tck_cycle(1'b0, 1'b0, bit_out); // Shift-IR, pattern loaded
        for (int i = 0; i < IR_WIDTH; i++) begin
            tck_cycle(i == IR_WIDTH - 1, code[i], bit_out); // Last bit exits
            captured[i] = bit_out;
        end
        tck_cycle(1'b1, 1'b0, bit_out); // Update-IR
        tck_cycle(1'b0, 1'b0, bit_out); // New code applied here
    endtask

    // LSB first, ends in Update-DR before the update edge
    task automatic scan_dr(input int n, input logic [35:0] data_in, output logic [35:0] captured);
        logic bit_out;
        captured = '0;
        tck_cycle(1'b1, 1'b0, bit_out); // Select-DR-Scan
        tck_cycle(1'b0, 1'b0, bit_out); // Capture-DR
        tck_cycle(1'b0, 1'b0, bit_out); // Shift-DR, register captured
        for (int i = 0; i < n; i++) begin
            tck_cycle(i == n - 1, data_in[i], bit_out);
            captured[i] = bit_out;
        end
        tck_cycle(1'b1, 1'b0, bit_out); // Update-DR
    endtask

    // Zero idle cycles keeps the direct Update to Select-DR path
    task automatic cdp_request(input logic [35:0] req_word, input int idle,
                               output logic [35:0] rsp_word);
        logic bit_out;
        scan_dr(DR_WIDTH, req_word, rsp_word);
        repeat (idle) tck_cycle(1'b0, 1'b0, bit_out);
    endtask

    task automatic cdp_expect(input string test_name, input logic [35:0] req_word,
                              input int idle, input logic [35:0] expected);
        logic [35:0] rsp;
        cdp_request(req_word, idle, rsp);
        check_value(test_name, expected, rsp);
    endtask

    function automatic logic [35:0] make_req(input logic [31:0] data, input logic [2:0] op,
                                             input logic wr);
        return {data, op, wr}; // data 35:4, op 3:1, wr 0
    endfunction

    function automatic logic [35:0] make_rsp(input logic [31:0] result, input logic [3:0] ack);
        return {result, ack};
    endfunction

    task automatic identification_after_reset();
        logic [35:0]         cap;
        logic [IR_WIDTH-1:0] ir_cap;
        tap_reset();
        goto_idle();
        scan_dr(DR_WIDTH, '0, cap); // IR defaults to JDPACC
        check_value("id_after_reset", DBG_PORT_ID, cap);
        goto_idle();
        scan_ir(IR_BYPASS, ir_cap);
        check_value("ir_capture", 36'(IR_CAPTURE), 36'(ir_cap));
    endtask

    task automatic bypass_path();
        logic [35:0] word;
        logic [35:0] cap;
        word[31:0]  = $urandom();
        word[35:32] = 4'($urandom());
        scan_dr(DR_WIDTH, word, cap);
        check_value("bypass_delay", {word[34:0], 1'b0}, cap); // One bit late, leading 0
        goto_idle();
    endtask

    task automatic select_taddr_readback();
        logic [31:0]         sel_val;
        logic [31:0]         addr_val;
        logic [IR_WIDTH-1:0] ir_cap;
        sel_val  = $urandom();
        addr_val = $urandom();
        scan_ir(IR_CDPACC, ir_cap);
        check_value("cdpacc_ir_capture", 36'(IR_CAPTURE), 36'(ir_cap));
        cdp_expect("first_response", make_req(sel_val, SELECT, 1'b1), 1, make_rsp('0, ACK_OK));
        cdp_expect("select_write", make_req('0, SELECT, 1'b0), 1, make_rsp(sel_val, ACK_OK));
        cdp_expect("select_read", make_req(addr_val, TADDR, 1'b1), 1, make_rsp(sel_val, ACK_OK));
        cdp_expect("taddr_write", make_req('0, TADDR, 1'b0), 1, make_rsp(addr_val, ACK_OK));
        cdp_expect("taddr_read", make_req('0, SELECT, 1'b1), 1, make_rsp(addr_val, ACK_OK));
    endtask

    task automatic data_transfer_banks();
        logic [31:0] data_1;
        logic [35:0] rsp;
        bank_addr = 5'($urandom());
        data_0    = $urandom();
        data_1    = $urandom();
        cdp_expect("select_bank0", make_req(32'(bank_addr), TADDR, 1'b1), 1,
                   make_rsp('0, ACK_OK));
        cdp_expect("taddr_set", make_req(data_0, DTR, 1'b1), 2, make_rsp(32'(bank_addr), ACK_OK));
        cdp_request(make_req('0, DTR, 1'b0), 2, rsp);
        check_value("write_ack_bank0", 36'(ACK_OK), 36'(rsp[3:0]));
        cdp_expect("read_bank0", make_req(32'd1, SELECT, 1'b1), 1, make_rsp(data_0, ACK_OK));
        cdp_expect("select_bank1", make_req('0, DTR, 1'b0), 2, make_rsp(32'd1, ACK_OK));
        cdp_expect("bank1_isolated", make_req(data_1, DTR, 1'b1), 2, make_rsp('0, ACK_OK));
        cdp_request(make_req('0, DTR, 1'b0), 2, rsp);
        check_value("write_ack_bank1", 36'(ACK_OK), 36'(rsp[3:0]));
        cdp_expect("read_bank1", make_req('0, SELECT, 1'b1), 1, make_rsp(data_1, ACK_OK));
        cdp_expect("reselect_bank0", make_req('0, DTR, 1'b0), 2, make_rsp('0, ACK_OK));
        cdp_expect("bank0_kept", make_req('0, SELECT, 1'b0), 1, make_rsp(data_0, ACK_OK));
    endtask

    task automatic busy_wait_ack();
        // Bank 0 selected, address and data left by the transfer test
        cdp_expect("busy_setup", make_req('0, DTR, 1'b0), 0, make_rsp('0, ACK_OK));
        cdp_expect("busy_wait", make_req('0, DTR, 1'b0), 2, make_rsp('0, ACK_WAIT));
        cdp_expect("busy_result", make_req('0, SELECT, 1'b0), 1, make_rsp(data_0, ACK_OK));
    endtask

    task automatic faults_and_reset();
        logic [35:0]         cap;
        logic [IR_WIDTH-1:0] ir_cap;
        cdp_expect("before_fault", make_req('0, 3'd5, 1'b0), 1, make_rsp('0, ACK_OK));
        cdp_expect("invalid_op", make_req(32'd2, SELECT, 1'b1), 1, make_rsp('0, ACK_FAULT));
        cdp_expect("select_2", make_req($urandom(), DTR, 1'b1), 2, make_rsp(32'd2, ACK_OK));
        cdp_expect("bad_bank", make_req('0, SELECT, 1'b1), 1, make_rsp('0, ACK_FAULT));
        cdp_expect("back_to_bank0", make_req('0, DTR, 1'b0), 2, make_rsp('0, ACK_OK));
        cdp_expect("bank0_unchanged", make_req('0, SELECT, 1'b0), 1, make_rsp(data_0, ACK_OK));
        state_test_logic_reset <= 1'b1; // Pin reset mid-run
        tms                    <= 1'b1;
        repeat (4) @(posedge tck);
        state_test_logic_reset <= 1'b0;
        tap_reset();
        goto_idle();
        scan_dr(DR_WIDTH, '0, cap);
        check_value("ir_after_reset", DBG_PORT_ID, cap);
        goto_idle();
        scan_ir(IR_CDPACC, ir_cap);
        cdp_expect("port_after_reset", make_req('0, SELECT, 1'b1), 1, make_rsp('0, ACK_OK));
        cdp_expect("select_after_reset", make_req(32'(bank_addr), TADDR, 1'b1), 1,
                   make_rsp('0, ACK_OK));
        cdp_expect("taddr_after_reset", make_req('0, DTR, 1'b0), 2,
                   make_rsp(32'(bank_addr), ACK_OK));
        cdp_expect("bank0_cleared", make_req('0, SELECT, 1'b0), 1, make_rsp('0, ACK_OK));
    endtask

    initial begin
        state_test_logic_reset = 1'b1;
        tms                    = 1'b1;
        tdi                    = 1'b0;
        bank_addr              = '0;
        data_0                 = '0;
        void'($urandom(523));
        repeat (RESET_CYCLES) @(posedge tck);
        state_test_logic_reset <= 1'b0;
        identification_after_reset();
        bypass_path();
        select_taddr_readback();
        data_transfer_banks();
        busy_wait_ack();
        faults_and_reset();
        $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tests/jtag_dbg_chk.sv ====
// Bus and tdo protocol assertions, bound into the JTAG debug top level
// Failures raise $error from the assertion action blocks
`timescale 1ns/1ps
`default_nettype none

module jtag_dbg_chk (
    input logic                               tck,
    input logic                               state_test_logic_reset,
    input logic                               tdo,
    input logic [dbg_pkg::MEMI_NR_SLAVES-1:0] memi_sel,
    input logic [dbg_pkg::MEMI_NR_SLAVES-1:0] memi_ready,
    input jtag_pkg::tap_state_t               tap_state
);

    import jtag_pkg::*;

    sel_onehot: assert property (@(posedge tck) disable iff (state_test_logic_reset)
        $onehot0(memi_sel))
        else $error("memi_sel has more than one bank selected");

    sel_single_cycle: assert property (@(posedge tck) disable iff (state_test_logic_reset)
        (|memi_sel) |=> !(|memi_sel))
        else $error("memi_sel held high for two cycles");

    ready_follows_sel: assert property (@(posedge tck) disable iff (state_test_logic_reset)
        memi_ready == $past(memi_sel))
        else $error("memi_ready not one cycle behind memi_sel");

    tdo_quiet: assert property (@(posedge tck)
        !(tap_state inside {SHIFT_DR, SHIFT_IR}) |-> !tdo)
        else $error("tdo high outside the shift states");

endmodule

bind jtag_dbg_top jtag_dbg_chk jtag_dbg_chk_i (
    .tck                    (tck),
    .state_test_logic_reset (state_test_logic_reset),
    .tdo                    (tdo),
    .memi_sel               (memi_if_i.memi_sel),
    .memi_ready             (memi_if_i.memi_ready),
    .tap_state              (tap_controller_i.tap_state)
);

`default_nettype wire

// ==== tests/tb_clock.sv ====
// Free-running tck source for the testbench, 4 ns period
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter real PERIOD_NS = 4.0 // Full tck period
) (
    output logic tck
);

    initial tck = 1'b0;

    always #(PERIOD_NS / 2.0) tck = ~tck; // 50 percent duty

endmodule

`default_nettype wire

// ==== source/jtag_dbg_top.sv ====
// JTAG debug access top level with TAP, core debug port and two register banks
// All logic runs on tck, the pin reset also clears the banks
`timescale 1ns/1ps
`default_nettype none

module jtag_dbg_top (
    input  logic tck,
    input  logic state_test_logic_reset,
    input  logic tms,
    input  logic tdi,
    output logic tdo
);

    logic jdpacc_tdo; // Scan outputs back to the TAP mux
    logic cdpacc_tdo;

    tap_ctrl_if tap_ctrl_if_i ();
    memi_if     memi_if_i ();

    tap_controller tap_controller_i (
        .tck                    (tck),
        .state_test_logic_reset (state_test_logic_reset),
        .tms                    (tms),
        .tdi                    (tdi),
        .tdo                    (tdo),
        .ctrl                   (tap_ctrl_if_i),
        .jdpacc_tdo             (jdpacc_tdo),
        .cdpacc_tdo             (cdpacc_tdo)
    );

    core_dbg_port core_dbg_port_i (
        .tck        (tck),
        .ctrl       (tap_ctrl_if_i),
        .jdpacc_tdo (jdpacc_tdo),
        .cdpacc_tdo (cdpacc_tdo),
        .memi       (memi_if_i)
    );

    dbg_reg_bank #(.SLAVE_INDEX(0)) dbg_reg_bank_0_i (
        .tck (tck), .state_test_logic_reset (state_test_logic_reset), .memi (memi_if_i)
    );

    dbg_reg_bank #(.SLAVE_INDEX(1)) dbg_reg_bank_1_i (
        .tck (tck), .state_test_logic_reset (state_test_logic_reset), .memi (memi_if_i)
    );

endmodule

`default_nettype wire

// ==== source/dbg_reg_bank.sv ====
// Debug register bank of 32 words, stand-in for the core debug logic
// Answers its sel bit on the memory bus with a ready pulse one cycle later
`timescale 1ns/1ps
`default_nettype none

module dbg_reg_bank #(
    parameter int SLAVE_INDEX = 0 // Position on the bus
) (
    input  logic  tck,
    input  logic  state_test_logic_reset,
    memi_if.slave memi
);

    import dbg_pkg::*;

    logic [MEMI_DATA_WIDTH-1:0] regs [2**MEMI_ADDR_WIDTH];
    logic [MEMI_DATA_WIDTH-1:0] rdata;
    logic                       ready;
    logic                       selected;

    assign selected = memi.memi_sel[SLAVE_INDEX];

    always_ff @(posedge tck) begin
        if (state_test_logic_reset) begin
            for (int i = 0; i < 2**MEMI_ADDR_WIDTH; i++) begin
                regs[i] <= '0; // Bank reads back zero after reset
            end
            ready <= 1'b0;
        end else begin
            ready <= selected;
            if (selected && memi.memi_wr_rd) begin
                regs[memi.memi_addr] <= memi.memi_wdata;
            end
        end
    end

    always_ff @(posedge tck) begin
        if (selected && !memi.memi_wr_rd) begin
            rdata <= regs[memi.memi_addr]; // Valid with ready
        end
    end

    assign memi.memi_ready[SLAVE_INDEX] = ready;
    assign memi.memi_rdata[SLAVE_INDEX] = rdata;

endmodule

`default_nettype wire

// ==== source/core_dbg_port.sv ====
// Core debug port holding the JDPACC and CDPACC scan registers
// CDPACC requests at Update-DR become memory bus accesses, answered at next Capture-DR
`timescale 1ns/1ps
`default_nettype none

module core_dbg_port (
    input  logic     tck,
    tap_ctrl_if.port ctrl,
    output logic     jdpacc_tdo,
    output logic     cdpacc_tdo,
    memi_if.master   memi
);

    import dbg_pkg::*;

    logic [DR_WIDTH-1:0]        jdpacc_reg;
    cdp_word_u                  cdpacc_reg;  // Request or response view
    cdp_req_t                   req;         // Request view of CDPACC
    logic [MEMI_DATA_WIDTH-1:0] select_reg;  // Bank index
    logic [MEMI_DATA_WIDTH-1:0] taddr_reg;   // Word address in bank
    logic [MEMI_DATA_WIDTH-1:0] result_reg;  // Returned at next capture
    logic [3:0]                 ack_reg;
    logic                       busy;        // Bus access outstanding
    logic [MEMI_NR_SLAVES-1:0]  sel_pending; // One-hot sel for next cycle
    logic [MEMI_NR_SLAVES-1:0]  sel_decode;
    logic                       select_fault;
    logic                       cdp_update;
    logic                       dtr_issue;
    logic [MEMI_DATA_WIDTH-1:0] bus_rdata;
    logic                       bus_ready;

    assign jdpacc_tdo = jdpacc_reg[0];
    assign cdpacc_tdo = cdpacc_reg[0];
    assign req        = cdpacc_reg.req;
    assign cdp_update = ctrl.insn_cdpacc_select && ctrl.state_update_dr;

    // JDPACC only reports the port ID, updates are ignored
    always_ff @(posedge tck) begin
        if (ctrl.insn_jdpacc_select && ctrl.state_capture_dr) begin
            jdpacc_reg <= DBG_PORT_ID;
        end else if (ctrl.insn_jdpacc_select && ctrl.state_shift_dr) begin
            jdpacc_reg <= {ctrl.tdi, jdpacc_reg[DR_WIDTH-1:1]};
        end
    end

    always_ff @(posedge tck) begin
        if (ctrl.insn_cdpacc_select && ctrl.state_capture_dr) begin
            cdpacc_reg.rsp <= '{result: busy ? '0 : result_reg,
                                ack:    busy ? ACK_WAIT : ack_reg};
        end else if (ctrl.insn_cdpacc_select && ctrl.state_shift_dr) begin
            cdpacc_reg <= {ctrl.tdi, cdpacc_reg[DR_WIDTH-1:1]};
        end
    end

    always_comb begin
        for (int i = 0; i < MEMI_NR_SLAVES; i++) begin
            sel_decode[i] = (select_reg == MEMI_DATA_WIDTH'(i));
        end
    end

    assign select_fault = (select_reg >= MEMI_DATA_WIDTH'(MEMI_NR_SLAVES)); // No such bank
    assign dtr_issue    = cdp_update && (req.op == DTR) && !busy && !select_fault;

    // Read data from whichever bank answers
    always_comb begin
        bus_rdata = '0;
        for (int i = 0; i < MEMI_NR_SLAVES; i++) begin
            if (memi.memi_ready[i]) begin
                bus_rdata = memi.memi_rdata[i];
            end
        end
    end

    assign bus_ready = |memi.memi_ready;

    always_ff @(posedge tck) begin
        if (ctrl.state_test_logic_reset) begin
            select_reg  <= '0;
            taddr_reg   <= '0;
            result_reg  <= '0;
            ack_reg     <= ACK_OK;
            busy        <= 1'b0;
            sel_pending <= '0;
        end else begin
            sel_pending <= '0; // Single-cycle request
            if (cdp_update) begin
                case (req.op)
                    SELECT: begin
                        if (req.wr) begin
                            select_reg <= req.data;
                        end
                        result_reg <= req.wr ? req.data : select_reg; // Echo register
                        ack_reg    <= ACK_OK;
                    end
                    TADDR: begin
                        if (req.wr) begin
                            taddr_reg <= req.data;
                        end
                        result_reg <= req.wr ? req.data : taddr_reg;
                        ack_reg    <= ACK_OK;
                    end
                    DTR: begin
                        if (!busy && select_fault) begin // Busy drops the request
                            result_reg <= '0;
                            ack_reg    <= ACK_FAULT;
                        end else if (dtr_issue) begin
                            sel_pending <= sel_decode;
                            busy        <= 1'b1;
                        end
                    end
                    default: begin
                        result_reg <= '0;
                        ack_reg    <= ACK_FAULT; // Unknown op
                    end
                endcase
            end
            if (busy && bus_ready) begin
                busy       <= 1'b0;
                result_reg <= memi.memi_wr_rd ? memi.memi_wdata : bus_rdata;
                ack_reg    <= ACK_OK;
            end
        end
    end

    always_ff @(posedge tck) begin
        if (ctrl.state_test_logic_reset) begin
            memi.memi_sel <= '0;
        end else begin
            memi.memi_sel <= sel_pending; // Goes out one edge after Update-DR
        end
    end

    // Address and data held until the next issue
    always_ff @(posedge tck) begin
        if (dtr_issue) begin
            memi.memi_addr  <= taddr_reg[MEMI_ADDR_WIDTH-1:0];
            memi.memi_wr_rd <= req.wr;
            memi.memi_wdata <= req.data;
        end
    end

endmodule

`default_nettype wire

// ==== source/tap_controller.sv ====
// JTAG TAP controller with the 16-state machine, instruction register and bypass
// Exports decoded strobes to the debug port and muxes tdo from the selected register
`timescale 1ns/1ps
`default_nettype none

module tap_controller (
    input  logic    tck,
    input  logic    state_test_logic_reset, // Synchronous reset pin
    input  logic    tms,
    input  logic    tdi,
    output logic    tdo,
    tap_ctrl_if.tap ctrl,
    input  logic    jdpacc_tdo,             // JDPACC bit 0
    input  logic    cdpacc_tdo              // CDPACC bit 0
);

    import jtag_pkg::*;

    tap_state_t          tap_state;
    tap_state_t          tap_state_next;
    logic [IR_WIDTH-1:0] ir_shift; // IR scan stage
    logic [IR_WIDTH-1:0] ir;       // Active instruction
    logic                bypass;
    logic                tap_reset;

    assign tap_reset = state_test_logic_reset || (tap_state == TEST_LOGIC_RESET);

    always_comb begin
        case (tap_state)
            TEST_LOGIC_RESET: tap_state_next = tms ? TEST_LOGIC_RESET : RUN_TEST_IDLE;
            RUN_TEST_IDLE:    tap_state_next = tms ? SELECT_DR_SCAN : RUN_TEST_IDLE;
            SELECT_DR_SCAN:   tap_state_next = tms ? SELECT_IR_SCAN : CAPTURE_DR;
            CAPTURE_DR:       tap_state_next = tms ? EXIT1_DR : SHIFT_DR;
            SHIFT_DR:         tap_state_next = tms ? EXIT1_DR : SHIFT_DR;
            EXIT1_DR:         tap_state_next = tms ? UPDATE_DR : PAUSE_DR;
            PAUSE_DR:         tap_state_next = tms ? EXIT2_DR : PAUSE_DR;
            EXIT2_DR:         tap_state_next = tms ? UPDATE_DR : SHIFT_DR;
            UPDATE_DR:        tap_state_next = tms ? SELECT_DR_SCAN : RUN_TEST_IDLE;
            SELECT_IR_SCAN:   tap_state_next = tms ? TEST_LOGIC_RESET : CAPTURE_IR;
            CAPTURE_IR:       tap_state_next = tms ? EXIT1_IR : SHIFT_IR;
            SHIFT_IR:         tap_state_next = tms ? EXIT1_IR : SHIFT_IR;
            EXIT1_IR:         tap_state_next = tms ? UPDATE_IR : PAUSE_IR;
            PAUSE_IR:         tap_state_next = tms ? EXIT2_IR : PAUSE_IR;
            EXIT2_IR:         tap_state_next = tms ? UPDATE_IR : SHIFT_IR;
            UPDATE_IR:        tap_state_next = tms ? SELECT_DR_SCAN : RUN_TEST_IDLE;
            default:          tap_state_next = TEST_LOGIC_RESET;
        endcase
    end

    always_ff @(posedge tck) begin
        if (state_test_logic_reset) begin
            tap_state <= TEST_LOGIC_RESET; // Pin overrides tms
        end else begin
            tap_state <= tap_state_next;
        end
    end

    // IR scan stage, shifted LSB first
    always_ff @(posedge tck) begin
        if (tap_state == CAPTURE_IR) begin
            ir_shift <= IR_CAPTURE;
        end else if (tap_state == SHIFT_IR) begin
            ir_shift <= {tdi, ir_shift[IR_WIDTH-1:1]};
        end
    end

    always_ff @(posedge tck) begin
        if (tap_reset) begin
            ir <= IR_JDPACC; // Debug port ID readable straight after reset
        end else if (tap_state == UPDATE_IR) begin
            ir <= ir_shift;
        end
    end

    always_ff @(posedge tck) begin
        if (tap_state == CAPTURE_DR) begin
            bypass <= 1'b0;
        end else if (tap_state == SHIFT_DR) begin
            bypass <= tdi;
        end
    end

    assign ctrl.insn_jdpacc_select     = (ir == IR_JDPACC);
    assign ctrl.insn_cdpacc_select     = (ir == IR_CDPACC);
    assign ctrl.state_test_logic_reset = tap_reset; // Port clears on pin or TLR
    assign ctrl.state_capture_dr       = (tap_state == CAPTURE_DR);
    assign ctrl.state_shift_dr         = (tap_state == SHIFT_DR);
    assign ctrl.state_update_dr        = (tap_state == UPDATE_DR);
    assign ctrl.tdi                    = tdi;

    always_comb begin
        tdo = 1'b0; // Quiet outside the shift states
        if (tap_state == SHIFT_IR) begin
            tdo = ir_shift[0];
        end else if (tap_state == SHIFT_DR) begin
            case (ir)
                IR_JDPACC: tdo = jdpacc_tdo;
                IR_CDPACC: tdo = cdpacc_tdo;
                default:   tdo = bypass; // Bypass and all unknown codes
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== source/memi_if.sv ====
// Memory bus between the core debug port and the debug register banks
// One-cycle sel pulse starts an access, the bank answers with ready one cycle later
`timescale 1ns/1ps
`default_nettype none

interface memi_if;

    import dbg_pkg::*;

    logic [MEMI_NR_SLAVES-1:0]  memi_sel;   // One-hot access strobe
    logic [MEMI_ADDR_WIDTH-1:0] memi_addr;  // Word inside the bank
    logic                       memi_wr_rd; // High for write
    logic [MEMI_DATA_WIDTH-1:0] memi_wdata;
    logic [MEMI_DATA_WIDTH-1:0] memi_rdata [MEMI_NR_SLAVES]; // One word per bank
    logic [MEMI_NR_SLAVES-1:0]  memi_ready; // Per-bank done pulse

    modport master (
        output memi_sel, memi_addr, memi_wr_rd, memi_wdata,
        input  memi_rdata, memi_ready
    );

    modport slave (
        input  memi_sel, memi_addr, memi_wr_rd, memi_wdata,
        output memi_rdata, memi_ready
    );

endinterface

`default_nettype wire

// ==== source/tap_ctrl_if.sv ====
// Decoded TAP strobes from the TAP controller into the core debug port
// All signals are levels of the current TAP state and IR, sampled on tck
`timescale 1ns/1ps
`default_nettype none

interface tap_ctrl_if;

    logic insn_jdpacc_select;     // IR holds JDPACC
    logic insn_cdpacc_select;     // IR holds CDPACC
    logic state_test_logic_reset; // TAP in Test-Logic-Reset or reset pin high
    logic state_capture_dr;
    logic state_shift_dr;
    logic state_update_dr;
    logic tdi;                    // Scan data in

    modport tap (
        output insn_jdpacc_select, insn_cdpacc_select, state_test_logic_reset,
        output state_capture_dr, state_shift_dr, state_update_dr, tdi
    );

    modport port (
        input insn_jdpacc_select, insn_cdpacc_select, state_test_logic_reset,
        input state_capture_dr, state_shift_dr, state_update_dr, tdi
    );

endinterface

`default_nettype wire

// ==== source/dbg_pkg.sv ====
// Debug port definitions covering CDPACC request and response layouts,
// ack codes and the memory bus geometry toward the debug register banks
`default_nettype none

package dbg_pkg;

    localparam int DR_WIDTH        = 36; // JDPACC and CDPACC length
    localparam int MEMI_NR_SLAVES  = 2;  // Register banks on the bus
    localparam int MEMI_ADDR_WIDTH = 5;  // 32 words per bank
    localparam int MEMI_DATA_WIDTH = 32;

    localparam logic [DR_WIDTH-1:0] DBG_PORT_ID = 36'h0_1D0C_DB61; // Low nibble fixed at 0001

    // Request opcodes in bits 3:1 of the CDPACC word
    typedef enum logic [2:0] {
        SELECT = 3'd0, // Bank select register
        TADDR  = 3'd1, // Target address register
        DTR    = 3'd2  // Data transfer on the bus
    } cdp_op_t;

    localparam logic [3:0] ACK_OK    = 4'b0010; // Request served
    localparam logic [3:0] ACK_WAIT  = 4'b0001; // Bus access still in flight
    localparam logic [3:0] ACK_FAULT = 4'b0100; // Bad op or bank

    // Shifted in and decoded at Update-DR
    typedef struct packed {
        logic [MEMI_DATA_WIDTH-1:0] data; // 35:4
        cdp_op_t                    op;   // 3:1
        logic                       wr;   // 0
    } cdp_req_t;

    // Loaded at Capture-DR and shifted out, ack first
    typedef struct packed {
        logic [MEMI_DATA_WIDTH-1:0] result; // 35:4
        logic [3:0]                 ack;    // 3:0
    } cdp_rsp_t;

    // Same scan register, two meanings depending on the TAP state
    typedef union packed {
        cdp_req_t req;
        cdp_rsp_t rsp;
    } cdp_word_u;

endpackage

`default_nettype wire

// ==== source/jtag_pkg.sv ====
// TAP controller constants shared by the TAP and the testbench
// States use the conventional 1149.1 encoding, instructions are 4 bits wide
`default_nettype none

package jtag_pkg;

    localparam int IR_WIDTH = 4; // Instruction register length

    typedef enum logic [3:0] {
        EXIT2_DR         = 4'h0,
        EXIT1_DR         = 4'h1,
        SHIFT_DR         = 4'h2,
        PAUSE_DR         = 4'h3,
        SELECT_IR_SCAN   = 4'h4,
        UPDATE_DR        = 4'h5,
        CAPTURE_DR       = 4'h6,
        SELECT_DR_SCAN   = 4'h7,
        EXIT2_IR         = 4'h8,
        EXIT1_IR         = 4'h9,
        SHIFT_IR         = 4'hA,
        PAUSE_IR         = 4'hB,
        RUN_TEST_IDLE    = 4'hC,
        UPDATE_IR        = 4'hD,
        CAPTURE_IR       = 4'hE,
        TEST_LOGIC_RESET = 4'hF
    } tap_state_t;

    localparam logic [IR_WIDTH-1:0] IR_JDPACC  = 4'hA;    // Debug port ID register
    localparam logic [IR_WIDTH-1:0] IR_CDPACC  = 4'hB;    // Core debug access register
    localparam logic [IR_WIDTH-1:0] IR_BYPASS  = 4'hF;    // One-bit bypass path
    localparam logic [IR_WIDTH-1:0] IR_CAPTURE = 4'b0001; // Fixed Capture-IR pattern

endpackage

`default_nettype wire
